//--- shared_fifo_cfg_pkg.sv
// Size, latency and credit constants of the shared multi-FIFO buffer
`default_nettype none

package shared_fifo_cfg_pkg;

  // Logical FIFOs and physical banks
  localparam int NUM_FIFOS = 2;
  localparam int NUM_BANKS = 2;

  // Every FIFO owns a fixed region of FIFO_DEPTH entries
  localparam int FIFO_DEPTH = 8;
  localparam int RAM_ENTRIES = NUM_FIFOS * FIFO_DEPTH;

  // A flat address is {row, bank}, so the lowest bit picks the bank
  localparam int ROW_WIDTH = 3;
  localparam int BANK_ID_WIDTH = $clog2(NUM_BANKS);
  localparam int ADDR_WIDTH = ROW_WIDTH + BANK_ID_WIDTH;

  localparam int DATA_WIDTH = 16;

  // Cycles from a granted bank read to its data
  localparam int RAM_READ_LATENCY = 1;

  // Words a consumer may have in flight per FIFO after reset
  localparam int POP_CREDITS = 2;

  localparam int FIFO_ID_WIDTH = $clog2(NUM_FIFOS);

  // Counter widths for pointers, occupancy and pop credits
  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int OCC_WIDTH = $clog2(FIFO_DEPTH + 1);
  localparam int CREDIT_WIDTH = $clog2(POP_CREDITS + 1);

endpackage

`default_nettype wire

//--- shared_fifo_types_pkg.sv
// FIFO id type and the RAM address union with its flat and split views
`default_nettype none

package shared_fifo_types_pkg;

  import shared_fifo_cfg_pkg::*;

  typedef logic [FIFO_ID_WIDTH-1:0] fifo_id_t;

  // Row inside a bank and the bank that holds the entry
  typedef struct packed {
    logic [ROW_WIDTH-1:0]     row;
    logic [BANK_ID_WIDTH-1:0] bank;
  } ram_addr_split_t;

  // The control logic builds the flat word as region base plus pointer,
  // while the crossbar and the banks read it as row and bank
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    ram_addr_split_t       split;
  } ram_addr_u;

endpackage

`default_nettype wire

//--- shared_fifo_ifs.sv
// Interfaces fifo_rd_if and bank_rd_if with their modports
`timescale 1ns/1ps
`default_nettype none

// One FIFO's head-read request and its returned data
interface fifo_rd_if
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
();
  logic                  req_valid;
  logic                  req_ready;
  ram_addr_u             req_addr;
  logic                  data_valid;
  logic [DATA_WIDTH-1:0] data;

  modport ctrl (output req_valid, output req_addr,
                input req_ready, input data_valid, input data);

  modport xbar (input req_valid, input req_addr,
                output req_ready, output data_valid, output data);
endinterface

// Read port of one RAM bank
interface bank_rd_if
  import shared_fifo_cfg_pkg::*;
();
  logic                  rd_valid;
  logic [ROW_WIDTH-1:0]  rd_row;
  logic                  data_valid;
  logic [DATA_WIDTH-1:0] data;

  modport xbar (output rd_valid, output rd_row,
                input data_valid, input data);

  modport bank (input rd_valid, input rd_row,
                output data_valid, output data);
endinterface

`default_nettype wire

//--- shared_fifo_ram_bank.sv
// Single RAM bank with a write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_ram_bank
  import shared_fifo_cfg_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  wr_en,
  input  wire logic [ROW_WIDTH-1:0]  wr_row,
  input  wire logic [DATA_WIDTH-1:0] wr_data,
  bank_rd_if.bank                    rd
);

  // Each bank holds its share of the whole RAM
  logic [DATA_WIDTH-1:0] mem [RAM_ENTRIES/NUM_BANKS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.rd_valid) begin
      rd.data <= mem[rd.rd_row];
    end
  end

  // Data valid follows each read request by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd.data_valid <= 1'b0;
    end else begin
      rd.data_valid <= rd.rd_valid;
    end
  end

endmodule

`default_nettype wire

//--- shared_fifo_read_xbar.sv
// Read crossbar with per-bank round-robin arbitration and data return routing
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_read_xbar
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  fifo_rd_if.xbar   fifo_rd [NUM_FIFOS],
  bank_rd_if.xbar   bank_rd [NUM_BANKS]
);

  logic [NUM_FIFOS-1:0]                 req_valid;
  ram_addr_u                            req_addr  [NUM_FIFOS];
  logic [NUM_FIFOS-1:0]                 req_ready;
  logic [NUM_FIFOS-1:0]                 rsp_valid;
  logic [NUM_FIFOS-1:0][DATA_WIDTH-1:0] rsp_data;

  logic [NUM_BANKS-1:0][NUM_FIFOS-1:0]  grant;
  logic [NUM_BANKS-1:0]                 bank_dv;
  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_data;
  fifo_id_t                             resp_id   [NUM_BANKS];

  // Flatten the interface arrays so they can be indexed by a variable
  for (genvar f = 0; f < NUM_FIFOS; f++) begin : gen_fifo_port
    assign req_valid[f]          = fifo_rd[f].req_valid;
    assign req_addr[f]           = fifo_rd[f].req_addr;
    assign fifo_rd[f].req_ready  = req_ready[f];
    assign fifo_rd[f].data_valid = rsp_valid[f];
    assign fifo_rd[f].data       = rsp_data[f];
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    logic [NUM_FIFOS-1:0] want;
    fifo_id_t             winner;
    fifo_id_t             rr_ptr;
    fifo_id_t             id_pipe [RAM_READ_LATENCY];

    for (genvar f = 0; f < NUM_FIFOS; f++) begin : gen_want
      assign want[f] = req_valid[f] && (req_addr[f].split.bank == BANK_ID_WIDTH'(b));
    end

    // Search from the round-robin pointer for the first requester
    always_comb begin
      fifo_id_t idx;
      logic     found;
      found  = 1'b0;
      winner = rr_ptr;
      for (int k = 0; k < NUM_FIFOS; k++) begin
        idx = rr_ptr + fifo_id_t'(k);
        if (!found && want[idx]) begin
          found  = 1'b1;
          winner = idx;
        end
      end
    end

    assign grant[b] = (|want) ? (NUM_FIFOS'(1) << winner) : '0;

    // Priority moves to the FIFO after the last winner
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        rr_ptr <= '0;
      end else if (|want) begin
        rr_ptr <= winner + fifo_id_t'(1);
      end
    end

    assign bank_rd[b].rd_valid = |want;
    assign bank_rd[b].rd_row   = req_addr[winner].split.row;

    // Remember who asked until the bank answers
    always_ff @(posedge clk) begin
      id_pipe[0] <= winner;
      for (int s = 1; s < RAM_READ_LATENCY; s++) begin
        id_pipe[s] <= id_pipe[s-1];
      end
    end

    assign resp_id[b]   = id_pipe[RAM_READ_LATENCY-1];
    assign bank_dv[b]   = bank_rd[b].data_valid;
    assign bank_data[b] = bank_rd[b].data;
  end

  // A FIFO has one request per cycle, so at most one bank answers it
  always_comb begin
    for (int f = 0; f < NUM_FIFOS; f++) begin
      req_ready[f] = 1'b0;
      rsp_valid[f] = 1'b0;
      rsp_data[f]  = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        req_ready[f] = req_ready[f] | grant[b][f];
        if (bank_dv[b] && (resp_id[b] == fifo_id_t'(f))) begin
          rsp_valid[f] = 1'b1;
          rsp_data[f]  = bank_data[b];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- shared_fifo_ctrl.sv
// FIFO control with pointers, occupancy, pop credits, write steering and read requests
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_ctrl
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  push_valid,
  input  wire fifo_id_t                              push_fifo,
  input  wire logic [DATA_WIDTH-1:0]                 push_data,
  output logic [NUM_FIFOS-1:0]                       push_credit,
  output logic [NUM_FIFOS-1:0]                       pop_valid,
  output logic [NUM_FIFOS-1:0][DATA_WIDTH-1:0]       pop_data,
  input  wire logic [NUM_FIFOS-1:0]                  pop_credit,
  output logic [NUM_BANKS-1:0]                       wr_en,
  output logic [NUM_BANKS-1:0][ROW_WIDTH-1:0]        wr_row,
  output logic [DATA_WIDTH-1:0]                      wr_data,
  fifo_rd_if.ctrl                                    rd [NUM_FIFOS]
);

  logic [PTR_WIDTH-1:0]    head_ptr [NUM_FIFOS];
  logic [PTR_WIDTH-1:0]    tail_ptr [NUM_FIFOS];
  logic [OCC_WIDTH-1:0]    occ      [NUM_FIFOS];
  logic [CREDIT_WIDTH-1:0] credits  [NUM_FIFOS];

  ram_addr_u wr_addr;

  // First flat address of the region that a FIFO owns
  function automatic logic [ADDR_WIDTH-1:0] region_base(input fifo_id_t id);
    return ADDR_WIDTH'(id) * ADDR_WIDTH'(FIFO_DEPTH);
  endfunction

  // The tail entry of the target FIFO selects the bank to write
  assign wr_addr.flat = region_base(push_fifo) + ADDR_WIDTH'(tail_ptr[push_fifo]);
  assign wr_data      = push_data;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_wr_bank
    assign wr_en[b]  = push_valid && (wr_addr.split.bank == BANK_ID_WIDTH'(b));
    assign wr_row[b] = wr_addr.split.row;
  end

  for (genvar f = 0; f < NUM_FIFOS; f++) begin : gen_fifo
    logic      push_here;
    logic      grant;
    logic      credit_ret;
    ram_addr_u head_addr;

    assign push_here = push_valid && (push_fifo == fifo_id_t'(f));
    assign grant     = rd[f].req_valid && rd[f].req_ready;

    // A FIFO asks for its head only when a consumer slot is open
    assign head_addr.flat  = region_base(fifo_id_t'(f)) + ADDR_WIDTH'(head_ptr[f]);
    assign rd[f].req_valid = (occ[f] != '0) && (credits[f] != '0);
    assign rd[f].req_addr  = head_addr;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        head_ptr[f] <= '0;
        tail_ptr[f] <= '0;
        occ[f]      <= '0;
        credits[f]  <= CREDIT_WIDTH'(POP_CREDITS);
        credit_ret  <= 1'b0;
      end else begin
        if (push_here) begin
          tail_ptr[f] <= tail_ptr[f] + 1'b1;
        end
        if (grant) begin
          head_ptr[f] <= head_ptr[f] + 1'b1;
        end
        occ[f]     <= occ[f] + OCC_WIDTH'(push_here) - OCC_WIDTH'(grant);
        credits[f] <= credits[f] + CREDIT_WIDTH'(pop_credit[f]) - CREDIT_WIDTH'(grant);
        // The entry is free once its read has been granted
        credit_ret <= grant;
      end
    end

    assign push_credit[f] = credit_ret;

    // Returned words go straight out, in request order
    assign pop_valid[f] = rd[f].data_valid;
    assign pop_data[f]  = rd[f].data;
  end

endmodule

`default_nettype wire

//--- shared_fifo_top.sv
// Top level of the shared multi-FIFO buffer with control, crossbar and RAM banks
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_top
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
(
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            push_valid,
  input  wire fifo_id_t                        push_fifo,
  input  wire logic [DATA_WIDTH-1:0]           push_data,
  output logic [NUM_FIFOS-1:0]                 push_credit,
  output logic [NUM_FIFOS-1:0]                 pop_valid,
  output logic [NUM_FIFOS-1:0][DATA_WIDTH-1:0] pop_data,
  input  wire logic [NUM_FIFOS-1:0]            pop_credit
);

  logic [NUM_BANKS-1:0]                wr_en;
  logic [NUM_BANKS-1:0][ROW_WIDTH-1:0] wr_row;
  logic [DATA_WIDTH-1:0]               wr_data;

  fifo_rd_if fifo_rd [NUM_FIFOS] ();
  bank_rd_if bank_rd [NUM_BANKS] ();

  shared_fifo_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_fifo   (push_fifo),
    .push_data   (push_data),
    .push_credit (push_credit),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_credit  (pop_credit),
    .wr_en       (wr_en),
    .wr_row      (wr_row),
    .wr_data     (wr_data),
    .rd          (fifo_rd)
  );

  shared_fifo_read_xbar u_read_xbar (
    .clk     (clk),
    .rst_n   (rst_n),
    .fifo_rd (fifo_rd),
    .bank_rd (bank_rd)
  );

  // Even flat addresses live in bank 0 and odd ones in bank 1
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    shared_fifo_ram_bank u_ram_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en[b]),
      .wr_row  (wr_row[b]),
      .wr_data (wr_data),
      .rd      (bank_rd[b])
    );
  end

endmodule

`default_nettype wire

//--- shared_fifo_assertions.sv
// Concurrent checks on the read crossbar grants and bank read latency, with their bind
`timescale 1ns/1ps
`default_nettype none

module shared_fifo_assertions
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
(
  input wire logic                                clk,
  input wire logic                                rst_n,
  input wire logic [NUM_FIFOS-1:0]                req_valid,
  input wire ram_addr_u                           req_addr [NUM_FIFOS],
  input wire logic [NUM_FIFOS-1:0]                req_ready,
  input wire logic [NUM_BANKS-1:0][NUM_FIFOS-1:0] grant,
  input wire logic [NUM_BANKS-1:0]                bank_dv
);

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_check
    logic [NUM_FIFOS-1:0] asked;
    logic [NUM_FIFOS-1:0] taken;

    // A FIFO asks the bank that the bank field of its head address selects
    for (genvar f = 0; f < NUM_FIFOS; f++) begin : gen_fifo_req
      assign asked[f] = req_valid[f] && (req_addr[f].split.bank == BANK_ID_WIDTH'(b));
      assign taken[f] = asked[f] && req_ready[f];
    end

    // A bank completes at most one FIFO handshake per cycle
    a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(taken))
      else $error("Bank %0d granted more than one FIFO", b);

    a_grant_has_req : assert property (@(posedge clk) disable iff (!rst_n)
      (grant[b] & ~asked) == '0)
      else $error("Bank %0d granted a FIFO that made no request to it", b);

    // A bank reads exactly when it grants, so its data follows the grant
    a_read_latency : assert property (@(posedge clk) disable iff (!rst_n)
      bank_dv[b] == $past(|grant[b], RAM_READ_LATENCY))
      else $error("Bank %0d data_valid is not one cycle after its read", b);
  end

endmodule

bind shared_fifo_read_xbar shared_fifo_assertions u_xbar_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req_addr  (req_addr),
  .req_ready (req_ready),
  .grant     (grant),
  .bank_dv   (bank_dv)
);

`default_nettype wire

//--- tb_shared_fifo.sv
// Directed testbench for the shared multi-FIFO buffer with LFSR stimulus, scoreboards and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_shared_fifo
  import shared_fifo_cfg_pkg::*, shared_fifo_types_pkg::*;
();
  // All five tests together take a few hundred cycles
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 push_valid;
  fifo_id_t                             push_fifo;
  logic [DATA_WIDTH-1:0]                push_data;
  logic [NUM_FIFOS-1:0]                 push_credit;
  logic [NUM_FIFOS-1:0]                 pop_valid;
  logic [NUM_FIFOS-1:0][DATA_WIDTH-1:0] pop_data;
  logic [NUM_FIFOS-1:0]                 pop_credit;

  logic [31:0]           lfsr;
  int                    cycle;
  int                    errors;
  string                 test_name;
  bit                    hold;
  bit                    random_delay;
  logic [DATA_WIDTH-1:0] exp_q [NUM_FIFOS][$];
  int                    ret_q [NUM_FIFOS][$];
  int                    push_cred [NUM_FIFOS];
  int                    slots [NUM_FIFOS];
  int                    allow [NUM_FIFOS];
  int                    pop_cnt [NUM_FIFOS];
  int                    pulse_cnt [NUM_FIFOS];

  shared_fifo_top u_shared_fifo_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_fifo   (push_fifo),
    .push_data   (push_data),
    .push_credit (push_credit),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_credit  (pop_credit)
  );

  // Galois LFSR that steps once for every bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // The sender spends one credit per push and records the word in the scoreboard
  task automatic push_word(input int f, input logic [DATA_WIDTH-1:0] data);
    while (push_cred[f] == 0) next_cycle();
    push_valid = 1'b1;
    push_fifo  = fifo_id_t'(f);
    push_data  = data;
    exp_q[f].push_back(data);
    push_cred[f]--;
    next_cycle();
    push_valid = 1'b0;
  endtask

  // Consumer controls change at the falling edge, away from the credit driver
  task automatic set_hold(input bit value);
    @(negedge clk);
    hold = value;
    next_cycle();
  endtask

  task automatic release_one_credit();
    @(negedge clk);
    allow = '{default: 1};
    next_cycle();
  endtask

  function automatic bit drained();
    bit done;
    done = 1'b1;
    for (int f = 0; f < NUM_FIFOS; f++) begin
      done &= (exp_q[f].size() == 0) && (ret_q[f].size() == 0);
      done &= (slots[f] == POP_CREDITS) && (push_cred[f] == FIFO_DEPTH);
    end
    return done;
  endfunction

  task automatic wait_drain();
    while (!drained()) next_cycle();
    repeat (4) next_cycle();
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  // Monitor samples the outputs at the falling edge where they are stable
  initial begin
    forever begin
      @(negedge clk);
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (rst_n && push_credit[f]) begin
          push_cred[f]++;
          pulse_cnt[f]++;
          if (push_cred[f] > FIFO_DEPTH)
            report_error($sformatf("FIFO %0d returned more push credits than entries", f));
        end
        if (rst_n && pop_valid[f]) begin
          pop_cnt[f]++;
          if (exp_q[f].size() == 0)
            report_error($sformatf("FIFO %0d delivered a word that was never pushed", f));
          else
            check_value($sformatf("%s fifo %0d", test_name, f),
                        32'(exp_q[f].pop_front()), 32'(pop_data[f]));
          if (slots[f] == 0)
            report_error($sformatf("FIFO %0d delivered a word with no pop credit", f));
          else
            slots[f]--;
          ret_q[f].push_back(cycle + (random_delay ? int'(rand_bits(3)) : 0));
        end
      end
    end
  end

  // Consumer returns one pop credit per received word once its delay is over
  initial begin
    logic [NUM_FIFOS-1:0] ret;
    forever begin
      next_cycle();
      ret = '0;
      for (int f = 0; f < NUM_FIFOS; f++) begin
        if (ret_q[f].size() > 0 && ret_q[f][0] <= cycle && (!hold || allow[f] > 0)) begin
          ret[f] = 1'b1;
          void'(ret_q[f].pop_front());
          slots[f]++;
          if (hold) allow[f]--;
        end
      end
      pop_credit = ret;
    end
  end

  task automatic test_idle();
    test_name = "idle";
    repeat (10) begin
      @(negedge clk);
      check_value(test_name, 32'h0, 32'(pop_valid));
      check_value(test_name, 32'h0, 32'(push_credit));
    end
    next_cycle();
  endtask

  task automatic test_single_fifo();
    test_name    = "single_fifo";
    random_delay = 1'b0;
    pulse_cnt    = '{default: 0};
    repeat (FIFO_DEPTH) push_word(0, DATA_WIDTH'(rand_bits(DATA_WIDTH)));
    wait_drain();
    check_value(test_name, FIFO_DEPTH, pulse_cnt[0]);
    check_value(test_name, 0, pulse_cnt[1]);
  endtask

  // Both heads walk through alternating banks, so they collide often
  task automatic test_random_mix();
    int f;
    test_name    = "random_mix";
    random_delay = 1'b1;
    repeat (40) begin
      f = int'(rand_bits(1));
      push_word(f, DATA_WIDTH'(rand_bits(DATA_WIDTH)));
      if (rand_bits(2) == 0) next_cycle();
    end
    wait_drain();
  endtask

  task automatic test_credit_hold();
    test_name    = "credit_hold";
    random_delay = 1'b0;
    pop_cnt      = '{default: 0};
    set_hold(1'b1);
    repeat (POP_CREDITS + 3) begin
      push_word(0, DATA_WIDTH'(rand_bits(DATA_WIDTH)));
      push_word(1, DATA_WIDTH'(rand_bits(DATA_WIDTH)));
    end
    repeat (20) next_cycle();
    for (int r = 0; r < 3; r++) begin
      check_value(test_name, POP_CREDITS + r, pop_cnt[0]);
      check_value(test_name, POP_CREDITS + r, pop_cnt[1]);
      release_one_credit();
      repeat (10) next_cycle();
    end
    check_value(test_name, POP_CREDITS + 3, pop_cnt[0]);
    check_value(test_name, POP_CREDITS + 3, pop_cnt[1]);
    set_hold(1'b0);
    wait_drain();
  endtask

  // POP_CREDITS words leave each FIFO, so the sender fits that many more
  task automatic test_full_drain();
    int sent [NUM_FIFOS];
    int f;
    test_name    = "full_drain";
    random_delay = 1'b1;
    sent         = '{default: 0};
    pop_cnt      = '{default: 0};
    set_hold(1'b1);
    while (sent[0] + sent[1] < 2 * (FIFO_DEPTH + POP_CREDITS)) begin
      f = int'(rand_bits(1));
      if (sent[f] == FIFO_DEPTH + POP_CREDITS) f = 1 - f;
      push_word(f, DATA_WIDTH'(rand_bits(DATA_WIDTH)));
      sent[f]++;
    end
    repeat (20) next_cycle();
    for (int i = 0; i < NUM_FIFOS; i++) begin
      check_value(test_name, 0, push_cred[i]);
      check_value(test_name, POP_CREDITS, pop_cnt[i]);
    end
    pulse_cnt = '{default: 0};
    set_hold(1'b0);
    wait_drain();
    check_value(test_name, FIFO_DEPTH, pulse_cnt[0]);
    check_value(test_name, FIFO_DEPTH, pulse_cnt[1]);
  endtask

  initial begin
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_fifo    = '0;
    push_data    = '0;
    pop_credit   = '0;
    lfsr         = 32'h5c28;
    hold         = 1'b0;
    random_delay = 1'b0;
    push_cred    = '{default: FIFO_DEPTH};
    slots        = '{default: POP_CREDITS};
    allow        = '{default: 0};
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_idle();
    test_single_fifo();
    test_random_mix();
    test_credit_hold();
    test_full_drain();
    $display("Simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
shared_fifo_cfg_pkg.sv
shared_fifo_types_pkg.sv
shared_fifo_ifs.sv
shared_fifo_ram_bank.sv
shared_fifo_read_xbar.sv
shared_fifo_ctrl.sv
shared_fifo_top.sv
shared_fifo_assertions.sv
tb_shared_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shared FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_shared_fifo -f verilog.f

./obj_dir/Vtb_shared_fifo | tee sim.log

# The run counts as good only if the testbench reported success
grep -qx "test passed" sim.log
